// ==== project.f ====
verilog/corner_pkg.sv
verilog/edge_tracker.sv
verilog/corner_select.sv
verilog/quad_corner_finder.sv
testbench/quad_corner_finder_sva.sv
testbench/quad_corner_finder_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module quad_corner_finder_tb \
    -f project.f \
    -o quad_corner_finder_sim \
    || { echo "build failed"; exit 1; }

./obj_dir/quad_corner_finder_sim | tee /dev/stderr | grep -x "NO ERRORS" > /dev/null \
    && { echo "simulation passed"; exit 0; } \
    || { echo "simulation failed"; exit 1; }

// ==== testbench/quad_corner_finder_tb.sv ====
`timescale 1ns/1ps

module quad_corner_finder_tb;

    localparam int FRAME_W      = 640;
    localparam int FRAME_H      = 480;
    localparam int RESET_CYCLES = 8;
    localparam int FRAME_COUNT  = 15;   // five directed frames and ten random ones.
    localparam int MAX_PIXELS   = 40;   // longest pixel list of any frame.
    localparam int FRAME_TAIL   = 5;    // lead-in cycle plus four cycles of low sync.
    localparam int CYCLE_LIMIT  =
        2 * FRAME_COUNT * (MAX_PIXELS + FRAME_TAIL) + RESET_CYCLES;

    logic                       clk;
    logic                       reset;
    logic                       vga_vs;
    corner_pkg::pixel_t         pixel;
    corner_pkg::coord_t         threshold;
    corner_pkg::corners_t       corners;
    corner_pkg::thresh_flags_t  thresh_flags;

    corner_pkg::pixel_t         frame_px[$];   // entries of the frame being sent.
    corner_pkg::corners_t       exp_corners;
    corner_pkg::thresh_flags_t  flags_before_fall;
    logic                       armed_expected;
    event                       sync_fell;

    int corner_checks     = 0;
    int corner_errors     = 0;
    int flag_checks       = 0;
    int flag_errors       = 0;
    int test_count        = 0;
    int test_start_errors = 0;
    int cycle_count       = 0;

    quad_corner_finder #(
        .FRAME_WIDTH  (FRAME_W),
        .FRAME_HEIGHT (FRAME_H)
    ) dut_i (
        .clk          (clk),
        .reset        (reset),
        .vga_vs       (vga_vs),
        .pixel        (pixel),
        .threshold    (threshold),
        .corners      (corners),
        .thresh_flags (thresh_flags)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    // state of a tracker right after a reload.
    function automatic corner_pkg::extreme_t reload_state(input logic track_max,
                                                          input int prim_limit,
                                                          input int sec_limit);
        corner_pkg::extreme_t e;
        e.primary = track_max ? corner_pkg::coord_t'(0) : corner_pkg::coord_t'(prim_limit - 1);
        e.sec_max = corner_pkg::coord_t'(0);
        e.sec_min = corner_pkg::coord_t'(sec_limit - 1);
        e.count   = corner_pkg::coord_t'(0);
        return e;
    endfunction

    // one valid pixel applied to one extreme.
    function automatic corner_pkg::extreme_t track_step(input corner_pkg::extreme_t e,
                                                        input logic track_max,
                                                        input corner_pkg::coord_t prim,
                                                        input corner_pkg::coord_t sec);
        corner_pkg::extreme_t n;
        logic                 hit;
        n   = e;
        hit = track_max ? (prim >= e.primary) : (prim <= e.primary);
        if (hit) begin
            n.primary = prim;
            if (sec > e.sec_max) begin
                n.sec_max = sec;
            end
            if (sec < e.sec_min) begin
                n.sec_min = sec;
            end
            n.count = (prim == e.primary) ? e.count + corner_pkg::coord_t'(1)
                                          : corner_pkg::coord_t'(1);
        end
        return n;
    endfunction

    // replays the whole frame list and maps the four extremes onto corners.
    function automatic corner_pkg::corners_t expected_corners(input corner_pkg::coord_t thr);
        corner_pkg::extreme_t xmax;
        corner_pkg::extreme_t xmin;
        corner_pkg::extreme_t ymax;
        corner_pkg::extreme_t ymin;
        corner_pkg::corners_t c;
        xmax = reload_state(1'b1, FRAME_W, FRAME_H);
        xmin = reload_state(1'b0, FRAME_W, FRAME_H);
        ymax = reload_state(1'b1, FRAME_H, FRAME_W);
        ymin = reload_state(1'b0, FRAME_H, FRAME_W);
        foreach (frame_px[i]) begin
            if (frame_px[i].valid) begin
                xmax = track_step(xmax, 1'b1, frame_px[i].x, frame_px[i].y);
                xmin = track_step(xmin, 1'b0, frame_px[i].x, frame_px[i].y);
                ymax = track_step(ymax, 1'b1, frame_px[i].y, frame_px[i].x);
                ymin = track_step(ymin, 1'b0, frame_px[i].y, frame_px[i].x);
            end
        end
        if (ymin.count > thr || ymax.count > thr) begin
            c.top_left  = '{x: ymin.sec_min, y: ymin.primary};
            c.top_right = '{x: ymin.sec_max, y: ymin.primary};
            c.bot_left  = '{x: ymax.sec_min, y: ymax.primary};
            c.bot_right = '{x: ymax.sec_max, y: ymax.primary};
        end else begin
            c.top_left  = '{x: xmin.primary, y: xmin.sec_min};
            c.top_right = '{x: ymin.sec_max, y: ymin.primary};
            c.bot_left  = '{x: ymax.sec_min, y: ymax.primary};
            c.bot_right = '{x: xmax.primary, y: xmax.sec_max};
        end
        return c;
    endfunction

    function automatic string corners_text(input corner_pkg::corners_t c);
        return $sformatf("tl(%0d,%0d) tr(%0d,%0d) bl(%0d,%0d) br(%0d,%0d)",
                         c.top_left.x, c.top_left.y, c.top_right.x, c.top_right.y,
                         c.bot_left.x, c.bot_left.y, c.bot_right.x, c.bot_right.y);
    endfunction

    function automatic void add_pixel(input logic v, input int x, input int y);
        frame_px.push_back('{valid: v, x: corner_pkg::coord_t'(x), y: corner_pkg::coord_t'(y)});
    endfunction

    // sync high, the pixel list, then sync low for four cycles.
    task automatic run_frame(input corner_pkg::coord_t thr);
        corner_pkg::extreme_t       run_x_max;
        corner_pkg::extreme_t       run_x_min;
        corner_pkg::extreme_t       run_y_max;
        corner_pkg::extreme_t       run_y_min;
        corner_pkg::thresh_flags_t  want_flags;
        run_x_max = reload_state(1'b1, FRAME_W, FRAME_H);
        run_x_min = reload_state(1'b0, FRAME_W, FRAME_H);
        run_y_max = reload_state(1'b1, FRAME_H, FRAME_W);
        run_y_min = reload_state(1'b0, FRAME_H, FRAME_W);
        threshold = thr;
        vga_vs    = 1'b1;
        pixel     = '0;
        @(posedge clk);
        #1;
        foreach (frame_px[i]) begin
            pixel = frame_px[i];
            @(posedge clk);
            #1;
            if (armed_expected && frame_px[i].valid) begin
                run_x_max = track_step(run_x_max, 1'b1, frame_px[i].x, frame_px[i].y);
                run_x_min = track_step(run_x_min, 1'b0, frame_px[i].x, frame_px[i].y);
                run_y_max = track_step(run_y_max, 1'b1, frame_px[i].y, frame_px[i].x);
                run_y_min = track_step(run_y_min, 1'b0, frame_px[i].y, frame_px[i].x);
            end
            want_flags.x_max = run_x_max.count > thr;
            want_flags.x_min = run_x_min.count > thr;
            want_flags.y_max = run_y_max.count > thr;
            want_flags.y_min = run_y_min.count > thr;
            flag_checks = flag_checks + 1;
            if (thresh_flags !== want_flags) begin
                flag_errors = flag_errors + 1;
                $display("Error at %0t ns: thresh_flags %b, expected %b after entry %0d",
                         $time, thresh_flags, want_flags, i);
            end
        end
        flags_before_fall = thresh_flags;
        if (armed_expected) begin
            exp_corners = expected_corners(thr);
        end else begin
            exp_corners = '0;   // the arming frame leaves the corners alone.
        end
        pixel  = '0;
        vga_vs = 1'b0;
        -> sync_fell;
        armed_expected = 1'b1;
        repeat (4) begin
            @(posedge clk);
        end
        #1;
    endtask

    task automatic close_test(input string name);
        int errs;
        errs       = corner_errors + flag_errors - test_start_errors;
        test_count = test_count + 1;
        if (errs == 0) begin
            $display("test %0d, %s: passed", test_count, name);
        end else begin
            $display("test %0d, %s: %0d errors", test_count, name, errs);
        end
        test_start_errors = corner_errors + flag_errors;
    endtask

    always begin
        @(sync_fell);
        repeat (2) @(posedge clk);
        #2;
        corner_checks = corner_checks + 1;
        if (corners !== exp_corners) begin
            corner_errors = corner_errors + 1;
            $display("Error at %0t ns: corners %s, expected %s",
                     $time, corners_text(corners), corners_text(exp_corners));
        end
    end

    initial begin
        int f;
        int n;
        int k;
        void'($urandom(32'ha40f_2338));
        reset             = 1'b1;
        vga_vs            = 1'b0;
        pixel             = '0;
        threshold         = '0;
        armed_expected    = 1'b0;
        exp_corners       = '0;
        flags_before_fall = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;
        repeat (2) @(posedge clk);
        #1;

        frame_px.delete();
        add_pixel(1'b1, 320, 240);
        add_pixel(1'b1, 10, 20);
        add_pixel(1'b0, 0, 0);
        add_pixel(1'b1, 630, 470);
        run_frame(corner_pkg::coord_t'(2));
        close_test("first sync fall only arms");

        // a diamond with its points on the four extremes.
        frame_px.delete();
        add_pixel(1'b1, 320, 50);
        add_pixel(1'b0, 0, 0);
        add_pixel(1'b1, 600, 240);
        add_pixel(1'b1, 300, 200);
        add_pixel(1'b0, 639, 479);
        add_pixel(1'b1, 320, 430);
        add_pixel(1'b1, 40, 240);
        add_pixel(1'b1, 350, 260);
        run_frame(corner_pkg::coord_t'(5));
        close_test("diamond mapping");

        frame_px.delete();
        for (k = 0; k < 20; k++) begin
            add_pixel(1'b1, 200 + k, 60);
            if (k % 7 == 6) begin
                add_pixel(1'b0, 5, 5);
            end
        end
        for (k = 0; k < 10; k++) begin
            add_pixel(1'b1, 180 + k, 400);
        end
        add_pixel(1'b1, 150, 200);
        add_pixel(1'b1, 260, 300);
        run_frame(corner_pkg::coord_t'(8));
        flag_checks = flag_checks + 1;
        if (flags_before_fall.y_min !== 1'b1) begin
            flag_errors = flag_errors + 1;
            $display("Error at %0t ns: y_min flag low before the sync fall", $time);
        end
        close_test("flat mapping");

        // runs grow on all four extremes at once.
        frame_px.delete();
        for (k = 0; k < 5; k++) begin
            add_pixel(1'b1, 600, 100 + k);
            add_pixel(1'b1, 30, 150 + k);
            add_pixel(1'b1, 300 + k, 20);
            add_pixel(1'b1, 310 + k, 460);
            add_pixel(1'b0, 639, 0);
        end
        run_frame(corner_pkg::coord_t'(3));
        close_test("threshold flags");

        frame_px.delete();
        add_pixel(1'b0, 0, 0);
        add_pixel(1'b0, 639, 479);
        add_pixel(1'b0, 320, 240);
        add_pixel(1'b0, 0, 479);
        add_pixel(1'b0, 639, 0);
        add_pixel(1'b0, 100, 100);
        run_frame(corner_pkg::coord_t'(0));
        close_test("invalid pixels only");

        for (f = 0; f < 10; f++) begin
            frame_px.delete();
            n = $urandom_range(MAX_PIXELS, 10);
            for (k = 0; k < n; k++) begin
                add_pixel($urandom_range(3) != 0, $urandom_range(FRAME_W - 1),
                          ($urandom_range(1) == 0) ? 40 + 5 * $urandom_range(2)
                                                   : $urandom_range(FRAME_H - 1));
            end
            run_frame(corner_pkg::coord_t'($urandom_range(6)));
            close_test($sformatf("random frame %0d", f));
        end

        $display("tests %0d, checks %0d, errors %0d", test_count,
                 corner_checks + flag_checks, corner_errors + flag_errors);
        if (corner_errors + flag_errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// ==== testbench/quad_corner_finder_sva.sv ====
`timescale 1ns/1ps

module quad_corner_finder_sva (
    input logic                       clk,
    input logic                       reset,
    input logic                       vga_vs,
    input corner_pkg::corners_t       corners,
    input corner_pkg::thresh_flags_t  thresh_flags
);

    // a reset cycle clears the corners and the counts behind the flags.
    reset_clears: assert property (
        @(posedge clk) reset |=> (corners == '0 && thresh_flags == '0)
    ) else $error("corners or thresh_flags not zero after a reset cycle");

    // the corners only move at the edge that samples sync low after high.
    corners_hold: assert property (
        @(posedge clk) disable iff (reset)
        !($past(vga_vs, 2) && !$past(vga_vs)) |-> $stable(corners)
    ) else $error("corners changed without a sync fall");

endmodule

bind quad_corner_finder quad_corner_finder_sva sva_i (
    .clk          (clk),
    .reset        (reset),
    .vga_vs       (vga_vs),
    .corners      (corners),
    .thresh_flags (thresh_flags)
);

// ==== verilog/quad_corner_finder.sv ====
`timescale 1ns/1ps

module quad_corner_finder #(
    parameter int FRAME_WIDTH  = corner_pkg::FRAME_WIDTH_DEFAULT,
    parameter int FRAME_HEIGHT = corner_pkg::FRAME_HEIGHT_DEFAULT
) (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       vga_vs,
    input  corner_pkg::pixel_t         pixel,
    input  corner_pkg::coord_t         threshold,
    output corner_pkg::corners_t       corners,
    output corner_pkg::thresh_flags_t  thresh_flags
);

    logic                  armed;
    logic                  frame_end;
    corner_pkg::extreme_t  x_max;
    corner_pkg::extreme_t  x_min;
    corner_pkg::extreme_t  y_max;
    corner_pkg::extreme_t  y_min;

    // the x trackers run along x and keep the y span of their column.
    edge_tracker #(
        .TRACK_MAX       (1'b1),
        .PRIMARY_LIMIT   (FRAME_WIDTH),
        .SECONDARY_LIMIT (FRAME_HEIGHT)
    ) x_max_i (
        .clk       (clk),
        .reset     (reset),
        .armed     (armed),
        .frame_end (frame_end),
        .valid     (pixel.valid),
        .primary   (pixel.x),
        .secondary (pixel.y),
        .extreme   (x_max)
    );

    edge_tracker #(
        .TRACK_MAX       (1'b0),
        .PRIMARY_LIMIT   (FRAME_WIDTH),
        .SECONDARY_LIMIT (FRAME_HEIGHT)
    ) x_min_i (
        .clk       (clk),
        .reset     (reset),
        .armed     (armed),
        .frame_end (frame_end),
        .valid     (pixel.valid),
        .primary   (pixel.x),
        .secondary (pixel.y),
        .extreme   (x_min)
    );

    // the y trackers run along y and keep the x span of their row.
    edge_tracker #(
        .TRACK_MAX       (1'b1),
        .PRIMARY_LIMIT   (FRAME_HEIGHT),
        .SECONDARY_LIMIT (FRAME_WIDTH)
    ) y_max_i (
        .clk       (clk),
        .reset     (reset),
        .armed     (armed),
        .frame_end (frame_end),
        .valid     (pixel.valid),
        .primary   (pixel.y),
        .secondary (pixel.x),
        .extreme   (y_max)
    );

    edge_tracker #(
        .TRACK_MAX       (1'b0),
        .PRIMARY_LIMIT   (FRAME_HEIGHT),
        .SECONDARY_LIMIT (FRAME_WIDTH)
    ) y_min_i (
        .clk       (clk),
        .reset     (reset),
        .armed     (armed),
        .frame_end (frame_end),
        .valid     (pixel.valid),
        .primary   (pixel.y),
        .secondary (pixel.x),
        .extreme   (y_min)
    );

    corner_select corner_select_i (
        .clk          (clk),
        .reset        (reset),
        .vga_vs       (vga_vs),
        .threshold    (threshold),
        .x_max        (x_max),
        .x_min        (x_min),
        .y_max        (y_max),
        .y_min        (y_min),
        .armed        (armed),
        .frame_end    (frame_end),
        .corners      (corners),
        .thresh_flags (thresh_flags)
    );

endmodule

// ==== verilog/corner_select.sv ====
`timescale 1ns/1ps

module corner_select (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       vga_vs,
    input  corner_pkg::coord_t         threshold,
    input  corner_pkg::extreme_t       x_max,
    input  corner_pkg::extreme_t       x_min,
    input  corner_pkg::extreme_t       y_max,
    input  corner_pkg::extreme_t       y_min,
    output logic                       armed,
    output logic                       frame_end,
    output corner_pkg::corners_t       corners,
    output corner_pkg::thresh_flags_t  thresh_flags
);

    logic                  vs_prev;
    logic                  flat;
    corner_pkg::corners_t  next_corners;

    always_ff @(posedge clk) begin
        if (reset) begin
            vs_prev <= 1'b0;
        end else begin
            vs_prev <= vga_vs;
        end
    end

    // high in the cycle where sync is low after being sampled high.
    assign frame_end = vs_prev && !vga_vs;

    // The first frame end after reset only starts the trackers.
    // No corners come out of that partial frame.
    always_ff @(posedge clk) begin
        if (reset) begin
            armed <= 1'b0;
        end else if (frame_end) begin
            armed <= 1'b1;
        end
    end

    assign thresh_flags.x_max = x_max.count > threshold;
    assign thresh_flags.x_min = x_min.count > threshold;
    assign thresh_flags.y_max = y_max.count > threshold;
    assign thresh_flags.y_min = y_min.count > threshold;

    // a long top or bottom run means the shape sits level.
    assign flat = thresh_flags.y_max || thresh_flags.y_min;

    always_comb begin
        // top right and bottom left come from the y trackers in both mappings.
        next_corners.top_right = '{x: y_min.sec_max, y: y_min.primary};
        next_corners.bot_left  = '{x: y_max.sec_min, y: y_max.primary};
        if (flat) begin
            // the other corner of each level edge comes from the same row.
            next_corners.top_left  = '{x: y_min.sec_min, y: y_min.primary};
            next_corners.bot_right = '{x: y_max.sec_max, y: y_max.primary};
        end else begin
            // a tilted shape has one corner at each extreme.
            next_corners.top_left  = '{x: x_min.primary, y: x_min.sec_min};
            next_corners.bot_right = '{x: x_max.primary, y: x_max.sec_max};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            corners <= '0;
        end else if (frame_end && armed) begin
            corners <= next_corners;   // trackers still hold the finished frame here.
        end
    end

endmodule

// ==== verilog/edge_tracker.sv ====
`timescale 1ns/1ps

module edge_tracker #(
    parameter bit TRACK_MAX       = 1'b1,
    parameter int PRIMARY_LIMIT   = corner_pkg::FRAME_WIDTH_DEFAULT,
    parameter int SECONDARY_LIMIT = corner_pkg::FRAME_HEIGHT_DEFAULT
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  armed,
    input  logic                  frame_end,
    input  logic                  valid,
    input  corner_pkg::coord_t    primary,
    input  corner_pkg::coord_t    secondary,
    output corner_pkg::extreme_t  extreme
);

    // a max tracker starts at the low end of its axis and a min tracker at the high end.
    localparam corner_pkg::coord_t PRIMARY_RELOAD =
        TRACK_MAX ? corner_pkg::coord_t'(0) : corner_pkg::coord_t'(PRIMARY_LIMIT - 1);

    localparam corner_pkg::coord_t SECONDARY_RELOAD =
        corner_pkg::coord_t'(SECONDARY_LIMIT - 1);

    localparam corner_pkg::extreme_t RELOAD = '{
        primary: PRIMARY_RELOAD,
        sec_max: '0,
        sec_min: SECONDARY_RELOAD,
        count:   '0
    };

    logic beyond;    // pixel is at or past the stored extreme.
    logic on_edge;   // pixel lies exactly on the stored extreme.
    logic take;

    always_comb begin
        if (TRACK_MAX) begin
            beyond = primary >= extreme.primary;
        end else begin
            beyond = primary <= extreme.primary;
        end
    end

    assign on_edge = primary == extreme.primary;
    assign take    = armed && valid && beyond;

    always_ff @(posedge clk) begin
        if (reset || frame_end) begin
            extreme <= RELOAD;   // a frame end drops any pixel in the same cycle.
        end else if (take) begin
            extreme.primary <= primary;

            // the span is kept across moves of the extreme.
            if (secondary > extreme.sec_max) begin
                extreme.sec_max <= secondary;
            end
            if (secondary < extreme.sec_min) begin
                extreme.sec_min <= secondary;
            end

            if (on_edge) begin
                extreme.count <= extreme.count + 1'b1;
            end else begin
                extreme.count <= corner_pkg::coord_t'(1); // a new extreme starts a new run.
            end
        end
    end

endmodule

// ==== verilog/corner_pkg.sv ====
package corner_pkg;

    // every coordinate and every count fits in one 10-bit word.
    localparam int COORD_W = 10;

    localparam int FRAME_WIDTH_DEFAULT  = 640;
    localparam int FRAME_HEIGHT_DEFAULT = 480;

    typedef logic [COORD_W-1:0] coord_t;

    // one sample of the target mask with its screen position.
    typedef struct packed {
        logic   valid;
        coord_t x;
        coord_t y;
    } pixel_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
    } point_t;

    typedef struct packed {
        point_t top_left;
        point_t top_right;
        point_t bot_left;
        point_t bot_right;
    } corners_t;

    // running state of one extreme.
    // primary is on the tracker's own axis, the sec fields are on the cross axis.
    typedef struct packed {
        coord_t primary;
        coord_t sec_max;
        coord_t sec_min;
        coord_t count;   // pixels that sit on the current extreme.
    } extreme_t;

    typedef struct packed {
        logic x_max;
        logic x_min;
        logic y_max;
        logic y_min;
    } thresh_flags_t;

endpackage
